// ==== design/dramController_defines.svh ====
// cycle counts, field widths and mode word for the sdram controller, include where needed
`ifndef DRAMCONTROLLER_DEFINES_SVH
`define DRAMCONTROLLER_DEFINES_SVH

// timing in 50 MHz clock cycles
`define PowerUpCycles         4998    // 100 us with cke low
`define InitRefreshCycles     40      // length of the initial refresh train
`define ModeWaitCycles        3       // settle after mode register write
`define AutoRefreshWaitCycles 3       // trfc margin after a periodic refresh
`define CasWaitCycles         2       // read wait, matches cas latency 2
`define RefreshInterval       375     // 7.5 us between auto refreshes

// cas latency 2, burst length 1, sequential
`define ModeRegisterWord      13'h220

// widths
`define TimerWidth            16
`define DataWidth             16      // sdram and cpu data bus
`define RowWidth              13      // sdram address pins
`define BankWidth             2
`define ColumnWidth           10
`define CpuAddressWidth       32      // 68000 byte address

`endif

// ==== design/dramPkg.sv ====
// sdram command and controller state types, referenced by scoped name from the design
package dramPkg;

	// pin pattern ordered cke, cs, ras, cas, we
	typedef enum logic [4:0] {
		PoweringUp         = 5'b00000,  // cke and cs low while power settles
		Nop                = 5'b10111,
		Activate           = 5'b10011,  // row on address, bank on ba
		ReadAutoPrecharge  = 5'b10101,  // a10 high
		WriteAutoPrecharge = 5'b10100,  // a10 high
		PrechargeAll       = 5'b10010,  // a10 high, ba don't care
		AutoRefresh        = 5'b10001,
		ModeRegisterSet    = 5'b10000   // mode word on address
	} dramCommand;

	typedef enum logic [4:0] {
		InitialisingState       = 5'h00,  // load power up wait
		WaitPowerUpState        = 5'h01,
		FirstNopState           = 5'h02,
		InitPrechargeState      = 5'h03,
		InitPrechargeNopState   = 5'h04,  // load refresh train count
		InitRefreshState        = 5'h05,
		InitRefreshNopState     = 5'h06,
		ModeRegisterState       = 5'h07,
		ModeRegisterNopState    = 5'h08,
		IdleState               = 5'h09,
		RefreshPrechargeState   = 5'h0a,
		RefreshPrechargeNopState = 5'h0b,
		RefreshState            = 5'h0c,
		RefreshNopState         = 5'h0d,
		ReadingState            = 5'h0e,  // issue read after activate
		CasLatencyState         = 5'h0f,
		WaitStrobeState         = 5'h10,  // write waits for uds or lds
		WriteHoldState          = 5'h11,
		WaitTerminateState      = 5'h12   // wait for cpu to drop strobes
	} dramState;

endpackage

// ==== design/refreshScheduler.sv ====
// refresh interval countdown, flags the sequencer when a periodic auto refresh is due
`timescale 1ns/1ps
`include "dramController_defines.svh"

module refreshScheduler (
	input  logic Clock,
	input  logic Reset_L,
	input  logic RefreshRestart,       // one cycle pulse reloads the interval
	output logic RefreshDue            // level, high while count is zero
);

	logic [`TimerWidth-1:0] refreshCount;  // cycles left until next refresh

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			refreshCount <= '0;                                 // due until first restart
		end else if (RefreshRestart) begin
			refreshCount <= `TimerWidth'(`RefreshInterval);     // reload
		end else if (refreshCount != '0) begin
			refreshCount <= refreshCount - 1'b1;                // count down, park at zero
		end
	end

	assign RefreshDue = (refreshCount == '0);

endmodule

// ==== design/sdramSequencer.sv ====
// controller fsm with general timer, picks next sdram command, address and cpu responses
`timescale 1ns/1ps
`include "dramController_defines.svh"

module sdramSequencer (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  logic [`CpuAddressWidth-1:0] Address,
	input  logic                        UDS_L,
	input  logic                        LDS_L,
	input  logic                        DramSelect_L,
	input  logic                        WE_L,
	input  logic                        AS_L,
	input  logic                        RefreshDue,
	output logic                        RefreshRestart,
	output dramPkg::dramCommand         NextCommand,
	output logic [`RowWidth-1:0]        NextAddr,
	output logic [`BankWidth-1:0]       NextBank,
	output logic                        DriveDq,
	output logic                        LatchRead,
	output logic                        NextDtack_L,
	output logic                        NextCpuReset_L
);

	dramPkg::dramState state;                 // current fsm state
	dramPkg::dramState nextState;
	logic [`TimerWidth-1:0] timer;            // general countdown
	logic [`TimerWidth-1:0] timerValue;       // preload, per state
	logic                   timerLoad;
	logic                   timerDone;
	logic [`RowWidth-1:0]   rowField;         // address 23..11
	logic [`RowWidth-1:0]   columnAddr;       // a10 set for auto precharge
	logic [`BankWidth-1:0]  bankField;        // address 25..24
	logic                   strobeActive;     // either data strobe low

	assign rowField     = Address[`RowWidth+`ColumnWidth:`ColumnWidth+1];
	assign bankField    = Address[`BankWidth+`RowWidth+`ColumnWidth:`RowWidth+`ColumnWidth+1];
	assign columnAddr   = {{(`RowWidth-`ColumnWidth-1){1'b0}}, 1'b1, Address[`ColumnWidth:1]};
	assign strobeActive = !UDS_L || !LDS_L;
	assign timerDone    = (timer == '0);

	//////////////////////////////////////////////////////////////////////
	// state register and general timer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= dramPkg::InitialisingState;
			timer <= '0;
		end else begin
			state <= nextState;
			if (timerLoad) begin
				timer <= timerValue;           // preload from current state
			end else if (!timerDone) begin
				timer <= timer - 1'b1;         // stops at zero
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and decisions
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState      = state;                // hold unless moved
		timerLoad      = 1'b0;
		timerValue     = '0;
		RefreshRestart = 1'b0;
		NextCommand    = dramPkg::Nop;
		NextAddr       = '0;
		NextBank       = '0;
		DriveDq        = 1'b0;                 // dq released by default
		LatchRead      = 1'b0;
		NextDtack_L    = 1'b1;
		NextCpuReset_L = 1'b1;                 // cpu runs once init is done
		case (state)
			dramPkg::InitialisingState: begin
				NextCommand    = dramPkg::PoweringUp;
				NextCpuReset_L = 1'b0;
				timerLoad      = 1'b1;
				timerValue     = `TimerWidth'(`PowerUpCycles);  // 100 us
				nextState      = dramPkg::WaitPowerUpState;
			end
			dramPkg::WaitPowerUpState: begin
				NextCommand    = dramPkg::PoweringUp;              // cke stays low
				NextCpuReset_L = 1'b0;
				if (timerDone) nextState = dramPkg::FirstNopState;
			end
			dramPkg::FirstNopState: begin
				NextCpuReset_L = 1'b0;                           // first cke high cycle
				nextState      = dramPkg::InitPrechargeState;
			end
			dramPkg::InitPrechargeState: begin
				NextCommand    = dramPkg::PrechargeAll;
				NextAddr[10]   = 1'b1;                           // all banks
				NextCpuReset_L = 1'b0;
				nextState      = dramPkg::InitPrechargeNopState;
			end
			dramPkg::InitPrechargeNopState: begin
				NextCpuReset_L = 1'b0;
				timerLoad      = 1'b1;
				timerValue     = `TimerWidth'(`InitRefreshCycles);
				nextState      = dramPkg::InitRefreshState;
			end
			dramPkg::InitRefreshState: begin
				NextCommand    = dramPkg::AutoRefresh;
				NextCpuReset_L = 1'b0;
				nextState      = dramPkg::InitRefreshNopState;
			end
			dramPkg::InitRefreshNopState: begin
				NextCpuReset_L = 1'b0;
				if (timer == `TimerWidth'(1)) begin
					nextState = dramPkg::ModeRegisterState;    // train finished
				end else if (timer[1:0] == 2'b01) begin
					nextState = dramPkg::InitRefreshState;     // every fourth cycle
				end
			end
			dramPkg::ModeRegisterState: begin
				NextCommand    = dramPkg::ModeRegisterSet;
				NextAddr       = `ModeRegisterWord;
				NextCpuReset_L = 1'b0;
				timerLoad      = 1'b1;
				timerValue     = `TimerWidth'(`ModeWaitCycles);
				nextState      = dramPkg::ModeRegisterNopState;
			end
			dramPkg::ModeRegisterNopState: begin
				NextCpuReset_L = 1'b0;
				if (timerDone) begin
					RefreshRestart = 1'b1;                      // start refresh interval
					nextState      = dramPkg::IdleState;
				end
			end
			dramPkg::IdleState: begin
				if (RefreshDue) begin
					nextState = dramPkg::RefreshPrechargeState; // refresh beats access
				end else if (!DramSelect_L && !AS_L) begin
					NextCommand = dramPkg::Activate;
					NextAddr    = rowField;
					NextBank    = bankField;
					nextState   = WE_L ? dramPkg::ReadingState : dramPkg::WaitStrobeState;
				end
			end
			dramPkg::RefreshPrechargeState: begin
				NextCommand  = dramPkg::PrechargeAll;
				NextAddr[10] = 1'b1;
				nextState    = dramPkg::RefreshPrechargeNopState;
			end
			dramPkg::RefreshPrechargeNopState: begin
				nextState = dramPkg::RefreshState;                 // trp gap
			end
			dramPkg::RefreshState: begin
				NextCommand = dramPkg::AutoRefresh;
				timerLoad   = 1'b1;
				timerValue  = `TimerWidth'(`AutoRefreshWaitCycles);
				nextState   = dramPkg::RefreshNopState;
			end
			dramPkg::RefreshNopState: begin
				if (timerDone) begin
					RefreshRestart = 1'b1;
					nextState      = dramPkg::IdleState;
				end
			end
			dramPkg::ReadingState: begin
				NextCommand = dramPkg::ReadAutoPrecharge;
				NextAddr    = columnAddr;
				NextBank    = bankField;
				timerLoad   = 1'b1;
				timerValue  = `TimerWidth'(`CasWaitCycles);
				nextState   = dramPkg::CasLatencyState;
			end
			dramPkg::CasLatencyState: begin
				NextDtack_L = 1'b0;
				LatchRead   = 1'b1;                              // last falling edge holds data
				if (timerDone) nextState = dramPkg::WaitTerminateState;
			end
			dramPkg::WaitStrobeState: begin
				if (strobeActive) begin
					NextCommand = dramPkg::WriteAutoPrecharge;   // whole word, no mask
					NextAddr    = columnAddr;
					NextBank    = bankField;
					NextDtack_L = 1'b0;
					DriveDq     = 1'b1;
					nextState   = dramPkg::WriteHoldState;
				end
			end
			dramPkg::WriteHoldState: begin
				NextDtack_L = 1'b0;
				DriveDq     = 1'b1;                              // hold data past write edge
				nextState   = dramPkg::WaitTerminateState;
			end
			dramPkg::WaitTerminateState: begin
				if (strobeActive) begin
					NextDtack_L = 1'b0;                          // cpu still in its cycle
				end else begin
					nextState = dramPkg::IdleState;
				end
			end
			default: begin
				nextState = dramPkg::IdleState;
			end
		endcase
	end

endmodule

// ==== design/sdramIoRegister.sv ====
// pin register for sdram and cpu outputs, dq tristate and falling edge read latch
`timescale 1ns/1ps
`include "dramController_defines.svh"

module sdramIoRegister (
	input  logic                   Clock,
	input  logic                   Reset_L,
	input  logic [`DataWidth-1:0]  DataIn,
	input  dramPkg::dramCommand    NextCommand,
	input  logic [`RowWidth-1:0]   NextAddr,
	input  logic [`BankWidth-1:0]  NextBank,
	input  logic                   DriveDq,
	input  logic                   LatchRead,
	input  logic                   NextDtack_L,
	input  logic                   NextCpuReset_L,
	output logic                   SDram_CKE_H,
	output logic                   SDram_CS_L,
	output logic                   SDram_RAS_L,
	output logic                   SDram_CAS_L,
	output logic                   SDram_WE_L,
	output logic [`RowWidth-1:0]   SDram_Addr,
	output logic [`BankWidth-1:0]  SDram_BA,
	inout  wire  [`DataWidth-1:0]  SDram_DQ,
	output logic [`DataWidth-1:0]  DataOut,
	output logic                   Dtack_L,
	output logic                   ResetOut_L
);

	dramPkg::dramCommand    commandReg;   // registered pin pattern
	logic                   driveEnable;  // dq output enable
	logic [`DataWidth-1:0]  writeData;    // cpu data one cycle late, matches command

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			commandReg  <= dramPkg::PoweringUp;  // cke low
			SDram_Addr  <= '0;
			SDram_BA    <= '0;
			driveEnable <= 1'b0;
			Dtack_L     <= 1'b1;
			ResetOut_L  <= 1'b0;                 // hold cpu in reset
		end else begin
			commandReg  <= NextCommand;
			SDram_Addr  <= NextAddr;
			SDram_BA    <= NextBank;
			driveEnable <= DriveDq;
			Dtack_L     <= NextDtack_L;
			ResetOut_L  <= NextCpuReset_L;
		end
	end

	always_ff @(posedge Clock) begin
		writeData <= DataIn;
	end

	assign {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = commandReg;
	assign SDram_DQ = driveEnable ? writeData : 'z;  // released unless writing

	// mid cycle sample, dq settled after cas latency
	always_ff @(negedge Clock) begin
		if (LatchRead) DataOut <= SDram_DQ;
	end

endmodule

// ==== design/m68kDramController.sv ====
// top level sdram controller for a 68000 bus, connects scheduler, sequencer and pin register
`timescale 1ns/1ps
`include "dramController_defines.svh"

module m68kDramController (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  logic [`CpuAddressWidth-1:0] Address,       // cpu byte address
	input  logic [`DataWidth-1:0]       DataIn,        // cpu write data
	input  logic                        UDS_L,
	input  logic                        LDS_L,
	input  logic                        DramSelect_L,  // decoded dram select
	input  logic                        WE_L,          // low for write
	input  logic                        AS_L,
	output logic [`DataWidth-1:0]       DataOut,       // read data to cpu
	output logic                        SDram_CKE_H,
	output logic                        SDram_CS_L,
	output logic                        SDram_RAS_L,
	output logic                        SDram_CAS_L,
	output logic                        SDram_WE_L,
	output logic [`RowWidth-1:0]        SDram_Addr,
	output logic [`BankWidth-1:0]       SDram_BA,
	inout  wire  [`DataWidth-1:0]       SDram_DQ,
	output logic                        Dtack_L,
	output logic                        ResetOut_L     // cpu reset until init done
);

	logic                   refreshDue;
	logic                   refreshRestart;
	dramPkg::dramCommand    nextCommand;
	logic [`RowWidth-1:0]   nextAddr;
	logic [`BankWidth-1:0]  nextBank;
	logic                   driveDq;
	logic                   latchRead;
	logic                   nextDtack_L;
	logic                   nextCpuReset_L;

	refreshScheduler refreshScheduler (
		.Clock(Clock), .Reset_L(Reset_L),
		.RefreshRestart(refreshRestart), .RefreshDue(refreshDue)
	);

	sdramSequencer sdramSequencer (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .DramSelect_L(DramSelect_L), .WE_L(WE_L), .AS_L(AS_L),
		.RefreshDue(refreshDue), .RefreshRestart(refreshRestart),
		.NextCommand(nextCommand), .NextAddr(nextAddr), .NextBank(nextBank),
		.DriveDq(driveDq), .LatchRead(latchRead),
		.NextDtack_L(nextDtack_L), .NextCpuReset_L(nextCpuReset_L)
	);

	sdramIoRegister sdramIoRegister (
		.Clock(Clock), .Reset_L(Reset_L), .DataIn(DataIn),
		.NextCommand(nextCommand), .NextAddr(nextAddr), .NextBank(nextBank),
		.DriveDq(driveDq), .LatchRead(latchRead),
		.NextDtack_L(nextDtack_L), .NextCpuReset_L(nextCpuReset_L),
		.SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA), .SDram_DQ(SDram_DQ),
		.DataOut(DataOut), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L)
	);

endmodule

// ==== tests/sdramModel.sv ====
// behavioral sdram for the testbench, decodes pin commands, stores words and counts refreshes
`timescale 1ns/1ps
`include "dramController_defines.svh"

module sdramModel (
	input  logic                  Clock,
	input  logic                  CKE_H,
	input  logic                  CS_L,
	input  logic                  RAS_L,
	input  logic                  CAS_L,
	input  logic                  WE_L,
	input  logic [`RowWidth-1:0]  Addr,
	input  logic [`BankWidth-1:0] BA,
	inout  wire  [`DataWidth-1:0] DQ
);

	logic [`DataWidth-1:0] memory [int unsigned];       // sparse, keyed by bank, row, column
	logic [`RowWidth-1:0]  openRow [0:(1<<`BankWidth)-1]; // row opened by the last activate
	logic [4:0]            pins;                        // cke, cs, ras, cas, we
	integer                refreshCount = 0;
	integer                prechargeAllCount = 0;
	logic [`RowWidth-1:0]  modeWord = '0;               // last mode register write
	logic                  readPending = 1'b0;          // first cycle of cas latency
	logic [`DataWidth-1:0] pendingData;
	logic                  dqEnable = 1'b0;             // second cycle, word on dq
	logic [`DataWidth-1:0] dqData;

	assign pins = {CKE_H, CS_L, RAS_L, CAS_L, WE_L};
	assign DQ   = dqEnable ? dqData : 'z;

	function automatic int unsigned wordKey(input logic [`BankWidth-1:0] bank,
			input logic [`RowWidth-1:0] row, input logic [`ColumnWidth-1:0] column);
		return 32'({bank, row, column});
	endfunction

	// also read by the testbench to look into the array
	function automatic logic [`DataWidth-1:0] storedWord(input logic [`BankWidth-1:0] bank,
			input logic [`RowWidth-1:0] row, input logic [`ColumnWidth-1:0] column);
		int unsigned key;
		key = wordKey(bank, row, column);
		if (memory.exists(key)) return memory[key];
		return 'x;                                          // never written
	endfunction

	always @(posedge Clock) begin
		dqEnable    <= readPending;                         // drive for one cycle
		dqData      <= pendingData;
		readPending <= 1'b0;
		if (CKE_H) begin
			case (pins)
				dramPkg::Activate: openRow[BA] <= Addr;
				dramPkg::ReadAutoPrecharge: begin
					readPending <= 1'b1;
					pendingData <= storedWord(BA, openRow[BA], Addr[`ColumnWidth-1:0]);
				end
				dramPkg::WriteAutoPrecharge: begin
					memory[wordKey(BA, openRow[BA], Addr[`ColumnWidth-1:0])] = DQ;  // whole word
				end
				dramPkg::PrechargeAll:    prechargeAllCount = prechargeAllCount + 1;
				dramPkg::AutoRefresh:     refreshCount = refreshCount + 1;
				dramPkg::ModeRegisterSet: modeWord <= Addr;
				default: ;                                          // nop
			endcase
		end
	end

endmodule

// ==== tests/tbM68kDramController.sv ====
// directed testbench top that drives the 68000 sdram controller against sdramModel
`timescale 1ns/1ps
`include "dramController_defines.svh"

module tbM68kDramController;

	logic                        Clock;
	logic                        Reset_L;
	logic [`CpuAddressWidth-1:0] Address;
	logic [`DataWidth-1:0]       DataIn;
	logic                        UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	wire  [`DataWidth-1:0]       DataOut;
	wire                         SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	wire  [`RowWidth-1:0]        SDram_Addr;
	wire  [`BankWidth-1:0]       SDram_BA;
	wire  [`DataWidth-1:0]       SDram_DQ;
	wire                         Dtack_L, ResetOut_L;
	integer                      seed;
	integer                      cycleCount = 0;
	logic [`DataWidth-1:0]       expected [int unsigned];  // scoreboard
	logic [`CpuAddressWidth-1:0] writtenAddr [$];          // addresses safe to read back

	m68kDramController DUT (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address), .DataIn(DataIn),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .DramSelect_L(DramSelect_L), .WE_L(WE_L), .AS_L(AS_L),
		.DataOut(DataOut), .SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA), .SDram_DQ(SDram_DQ),
		.Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L)
	);

	sdramModel sdram (
		.Clock(Clock), .CKE_H(SDram_CKE_H), .CS_L(SDram_CS_L), .RAS_L(SDram_RAS_L),
		.CAS_L(SDram_CAS_L), .WE_L(SDram_WE_L), .Addr(SDram_Addr), .BA(SDram_BA), .DQ(SDram_DQ)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;        // 10 MHz bench clock
	end

	always @(posedge Clock) cycleCount <= cycleCount + 1;

	// init plus every test plus margin
	initial begin
		#(100 * (`PowerUpCycles + 20 * `RefreshInterval + 2000));
		$display("Error at %0d ns: watchdog expired before the tests finished", $time);
		$display("Testbench failed");
		$fatal(1);
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and bus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] expectedValue,
			input logic [31:0] actualValue);
		$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expectedValue,
			actualValue);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic reportProblem(input string what);
		$display("Error at %0d ns: %s", $time, what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic nextDrive;
		@(posedge Clock);
		#10;                               // inputs change after the edge
	endtask

	// row 23..11, bank 25..24, column 10..1
	function automatic int unsigned memKey(input logic [`CpuAddressWidth-1:0] addr);
		return 32'({addr[25:24], addr[23:11], addr[10:1]});
	endfunction

	task automatic busCycle(input logic isWrite, input logic [`CpuAddressWidth-1:0] addr,
			input logic [`DataWidth-1:0] data, input integer holdCycles,
			output logic [`DataWidth-1:0] readData);
		integer waitCount;
		integer maxRise;
		maxRise = (holdCycles > 0) ? 2 : 3;   // read without hold still finishes cas wait
		Address = addr;
		DataIn = data;
		WE_L = !isWrite;
		AS_L = 1'b0;
		DramSelect_L = 1'b0;
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		waitCount = 0;
		while (Dtack_L !== 1'b0 && waitCount < 40) begin   // a refresh may go first
			nextDrive;
			waitCount = waitCount + 1;
		end
		assert (Dtack_L === 1'b0) else reportProblem("Dtack_L never fell in the bus cycle");
		repeat (holdCycles) begin
			nextDrive;
			assert (Dtack_L === 1'b0) else reportMismatch("Dtack_L", 32'(1'b0), 32'(Dtack_L));
		end
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		AS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		waitCount = 0;
		while (Dtack_L !== 1'b1 && waitCount < 10) begin
			nextDrive;
			waitCount = waitCount + 1;
		end
		assert (waitCount <= maxRise)
		else reportProblem($sformatf("Dtack_L rose %0d cycles after strobe release, limit %0d",
			waitCount, maxRise));
		readData = DataOut;                // latched on the falling edge
	endtask

	task automatic cpuWrite(input logic [`CpuAddressWidth-1:0] addr,
			input logic [`DataWidth-1:0] data, input integer holdCycles);
		logic [`DataWidth-1:0] unused;
		busCycle(1'b1, addr, data, holdCycles, unused);
		expected[memKey(addr)] = data;
		writtenAddr.push_back(addr);
	endtask

	task automatic cpuRead(input logic [`CpuAddressWidth-1:0] addr, input integer holdCycles,
			output logic [`DataWidth-1:0] readData);
		busCycle(1'b0, addr, '0, holdCycles, readData);
		assert (readData === expected[memKey(addr)])
		else reportMismatch("DataOut", 32'(expected[memKey(addr)]), 32'(readData));
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetInitTest;
		integer cycles;
		integer limit;
		limit = `PowerUpCycles + `InitRefreshCycles + 20;
		repeat (3) @(posedge Clock);
		#10;
		assert (SDram_CKE_H === 1'b0)
		else reportMismatch("SDram_CKE_H", 32'(1'b0), 32'(SDram_CKE_H));
		assert (Dtack_L === 1'b1) else reportMismatch("Dtack_L", 32'(1'b1), 32'(Dtack_L));
		assert (ResetOut_L === 1'b0)
		else reportMismatch("ResetOut_L", 32'(1'b0), 32'(ResetOut_L));
		Reset_L = 1'b1;
		repeat (`PowerUpCycles) nextDrive;
		assert (ResetOut_L === 1'b0)
		else reportMismatch("ResetOut_L", 32'(1'b0), 32'(ResetOut_L));
		cycles = `PowerUpCycles;
		while (ResetOut_L !== 1'b1 && cycles < limit) begin
			nextDrive;
			cycles = cycles + 1;
		end
		assert (ResetOut_L === 1'b1) else reportProblem("ResetOut_L did not rise after init");
		assert (sdram.prechargeAllCount == 1)
		else reportMismatch("sdram.prechargeAllCount", 32'(1), 32'(sdram.prechargeAllCount));
		assert (sdram.refreshCount >= 8)
		else reportMismatch("sdram.refreshCount", 32'(8), 32'(sdram.refreshCount));
		assert (sdram.modeWord === `ModeRegisterWord)
		else reportMismatch("sdram.modeWord", 32'(`ModeRegisterWord), 32'(sdram.modeWord));
	endtask

	task automatic writeReadTest;
		logic [`CpuAddressWidth-1:0] addr;
		logic [`DataWidth-1:0] readData;
		logic [`DataWidth-1:0] stored;
		addr = 32'h0123_4566;
		cpuWrite(addr, 16'ha5c3, 0);
		stored = sdram.storedWord(addr[25:24], addr[23:11], addr[10:1]);
		assert (stored === 16'ha5c3)
		else reportMismatch("sdram.memory", 32'h0000_a5c3, 32'(stored));
		cpuRead(addr, 0, readData);
	endtask

	task automatic addressMapTest;
		logic [`CpuAddressWidth-1:0] base;
		logic [`DataWidth-1:0] readData;
		base = 32'h0255_2a4c;
		cpuWrite(base, 16'h1111, 0);
		cpuWrite(base ^ 32'h0100_0000, 16'h2222, 0);   // bank only
		cpuWrite(base ^ 32'h0000_8000, 16'h3333, 0);   // row only
		cpuWrite(base ^ 32'h0000_0008, 16'h4444, 0);   // column only
		cpuRead(base, 0, readData);
		cpuRead(base ^ 32'h0100_0000, 0, readData);
		cpuRead(base ^ 32'h0000_8000, 0, readData);
		cpuRead(base ^ 32'h0000_0008, 0, readData);
		cpuRead(base | 32'h0000_0001, 0, readData);   // bit 0 aliases
		cpuRead(base ^ 32'hfc00_0000, 0, readData);   // top bits alias
		cpuWrite(base ^ 32'ha800_0001, 16'h7e81, 0);   // alias of base overwrites its word
		cpuRead(base, 0, readData);
	endtask

	task automatic dtackTimingTest;
		logic [`DataWidth-1:0] readData;
		cpuWrite(32'h00c0_1f30, 16'hbeef, 5);
		cpuRead(32'h00c0_1f30, 5, readData);
	endtask

	task automatic refreshLoadTest;
		integer startCycle;
		integer startRefresh;
		integer elapsed;
		integer choice;
		integer gap;
		int unsigned pick;
		logic [`DataWidth-1:0] readData;
		startCycle = cycleCount;
		startRefresh = sdram.refreshCount;
		repeat (200) begin
			choice = $random(seed);
			if (writtenAddr.size() == 0 || choice[0]) begin
				cpuWrite($random(seed), 16'($random(seed)), 0);
			end else begin
				pick = $unsigned($random(seed)) % $unsigned(writtenAddr.size());
				cpuRead(writtenAddr[pick], 0, readData);
			end
			gap = $unsigned($random(seed)) % 8;
			repeat (gap) nextDrive;         // idle gap
		end
		elapsed = cycleCount - startCycle;
		assert (sdram.refreshCount - startRefresh >= elapsed / (`RefreshInterval + 20))
		else reportMismatch("sdram.refreshCount increase",
			32'(elapsed / (`RefreshInterval + 20)), 32'(sdram.refreshCount - startRefresh));
	endtask

	initial begin
		seed = 32'h09b2_8c93;
		Reset_L = 1'b0;
		Address = '0;
		DataIn = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		resetInitTest();
		writeReadTest();
		addressMapTest();
		dtackTimingTest();
		refreshLoadTest();
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+design
design/dramPkg.sv
design/refreshScheduler.sv
design/sdramSequencer.sv
design/sdramIoRegister.sv
design/m68kDramController.sv
tests/sdramModel.sv
tests/tbM68kDramController.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tbM68kDramController -o simTb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
output=$(./obj_dir/simTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
